/* tests/ciInputVectors.txt */
// ciN     operand A  operand B  expected result, all hex.
// swap (01), delay (06), gray (09), anything else answers zero.
01 12345678 00000000 78563412
01 12345678 00000001 34127856
01 deadbeef 00000000 efbeadde
01 a1b2c3d4 ffffffff b2a1d4c3
01 00ff00ff 00000002 ff00ff00
09 0000f800 00000000 00000035
09 000007e0 00000000 000000b6
09 0000001f 00000000 00000012
09 0000ffff 00000000 000000ff
09 00000000 00000000 00000000
09 abcdf800 00000000 00000035
09 55558410 00000000 00000082
06 00000000 00000000 00000000
06 00000001 00000000 00000000
06 00000002 00000000 00000000
06 00000003 00000000 00000000
06 00000004 00000000 00000000
00 12345678 9abcdef0 00000000
ff ffffffff ffffffff 00000000
07 00000005 00000001 00000000

/* list.f */
verilog/operandPkg.sv
verilog/ciPkg.sv
verilog/grayscaleConverter.sv
verilog/microDelayTimer.sv
verilog/ciSequencer.sv
verilog/ciDatapath.sv
verilog/ciUnit.sv
tests/ciUnit_chk.sv
tests/ciScoreboard.sv
tests/ciUnitTb.sv

/* tests/ciUnitTb.sv */
`timescale 1ns/100ps

module ciUnitTb;

  localparam int numTests      = 20;
  localparam int fieldsPerTest = 4;  // ciN, operand A, operand B, expected.
  localparam int waitLimit     = 400;

  logic               s_systemClock;
  logic               s_pllLocked;
  logic               reqValid;
  logic               reqReady;
  ciPkg::ciRequest_t  request;
  logic               respValid;
  logic               respReady;
  ciPkg::ciResponse_t response;
  logic [31:0]        expected;
  int                 responseCount;
  int                 errorCount;
  logic [31:0]        vectors [0:numTests*fieldsPerTest-1];
  logic [31:0]        lfsrState;
  logic               runAborted;

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic vectorsComplete();
    for (int i = 0; i < numTests * fieldsPerTest; i++) begin
      if ($isunknown(vectors[i])) return 1'b0;
    end
    return 1'b1;
  endfunction

  always #20 s_systemClock = ~s_systemClock;

  // random back-pressure, one bit per cycle.
  always @(negedge s_systemClock) begin
    lfsrState = lfsrStep(lfsrState);
    respReady = lfsrState[0];
  end

  ciUnit u_ciUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .reqValid     (reqValid),
    .reqReady     (reqReady),
    .request      (request),
    .respValid    (respValid),
    .respReady    (respReady),
    .response     (response)
  );

  ciScoreboard u_ciScoreboard (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .reqValid     (reqValid),
    .reqReady     (reqReady),
    .request      (request),
    .expected     (expected),
    .respValid    (respValid),
    .respReady    (respReady),
    .response     (response),
    .responseCount(responseCount),
    .errorCount   (errorCount)
  );

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic sendRequest(input int index);
    int waitCycles;
    request.ciN   = vectors[index*fieldsPerTest][7:0];
    request.dataA = vectors[index*fieldsPerTest+1];
    request.dataB = vectors[index*fieldsPerTest+2];
    expected      = vectors[index*fieldsPerTest+3];
    reqValid      = 1'b1;
    waitCycles    = 0;
    while (!reqReady && (waitCycles < waitLimit)) begin
      @(negedge s_systemClock);
      waitCycles++;
    end
    if (!reqReady) begin
      $display("timeout: request %0d was not accepted within %0d cycles", index + 1, waitLimit);
      runAborted = 1'b1;
    end
    @(negedge s_systemClock);
    reqValid = 1'b0;
  endtask

  initial begin
    int waitCycles;
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    reqValid      = 1'b0;
    request       = '0;
    respReady     = 1'b0;
    expected      = '0;
    lfsrState     = 32'h6d8a3d07;
    runAborted    = 1'b0;
    $readmemh("tests/ciInputVectors.txt", vectors);
    if (!vectorsComplete()) begin
      $display("tests/ciInputVectors.txt is missing or holds fewer than %0d tests", numTests);
      runAborted = 1'b1;
    end
    repeat (8) @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    repeat (2) @(negedge s_systemClock);  // idle cycles for the reset check.
    for (int test = 0; (test < numTests) && !runAborted; test++) begin
      sendRequest(test);
    end
    waitCycles = 0;
    while (!runAborted && (responseCount < numTests) && (waitCycles < waitLimit)) begin
      @(negedge s_systemClock);
      waitCycles++;
    end
    if (!runAborted && (responseCount < numTests)) begin
      $display("timeout: only %0d of %0d responses arrived", responseCount, numTests);
      runAborted = 1'b1;
    end
    u_ciScoreboard.printCounts();
    if (runAborted || (errorCount != 0) ||
        (u_ciUnit.u_ciSequencer.u_ciUnitChk.assertFailures != 0)) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

/* tests/ciScoreboard.sv */
`timescale 1ns/100ps

module ciScoreboard (
  input  logic               s_systemClock,
  input  logic               s_pllLocked,
  input  logic               reqValid,
  input  logic               reqReady,
  input  ciPkg::ciRequest_t  request,
  input  logic [31:0]        expected,
  input  logic               respValid,
  input  logic               respReady,
  input  ciPkg::ciResponse_t response,
  output int                 responseCount,
  output int                 errorCount
);

  // one accepted request still waiting for its response.
  typedef struct packed {
    logic [7:0]  ciN;
    logic [15:0] usCount;
    logic [31:0] expected;
    logic [31:0] acceptCycle;
  } pendingTest_t;

  pendingTest_t pending[$];
  int           cycle = 0;
  int           riseCycle = 0;
  int           acceptCount = 0;
  int           passCount = 0;
  logic         respWasValid = 1'b0;
  logic         resetFailed = 1'b0;

  initial begin
    responseCount = 0;
    errorCount    = 0;
  end

  function automatic int minLatency(input logic [7:0] ciN, input logic [15:0] usCount);
    if (ciN == ciPkg::ciGray) return 4;  // two pipeline stages.
    if ((ciN == ciPkg::ciDelay) && (usCount != 0)) return usCount * ciPkg::ticksPerMicrosecond;
    return 2;
  endfunction

  function automatic int maxLatency(input logic [7:0] ciN, input logic [15:0] usCount);
    if ((ciN == ciPkg::ciDelay) && (usCount != 0)) begin
      return usCount * ciPkg::ticksPerMicrosecond + 3;
    end
    return minLatency(ciN, usCount);
  endfunction

  task automatic checkResponse(input pendingTest_t test, input logic [31:0] result,
                               input int latency);
    int   lo;
    int   hi;
    logic failed;
    lo     = minLatency(test.ciN, test.usCount);
    hi     = maxLatency(test.ciN, test.usCount);
    failed = 1'b0;
    if (result !== test.expected) begin
      $display("** Error test %0d: response.result = 0x%08h, expected 0x%08h",
               responseCount, result, test.expected);
      failed = 1'b1;
    end
    if ((latency < lo) || (latency > hi)) begin
      $display("test %0d: respValid rose %0d cycles after acceptance, allowed %0d to %0d",
               responseCount, latency, lo, hi);
      failed = 1'b1;
    end
    if (failed) begin
      errorCount++;
    end else begin
      passCount++;
      $display("test %0d: ciN 0x%02h result 0x%08h after %0d cycles ok",
               responseCount, test.ciN, result, latency);
    end
  endtask

  task automatic printCounts();
    $display("%0d responses checked, %0d passed, %0d errors",
             responseCount, passCount, errorCount);
  endtask

  always @(posedge s_systemClock) begin
    pendingTest_t head;
    pendingTest_t entry;
    if (s_pllLocked) begin
      // idle state must show until the first request.
      if ((acceptCount == 0) && !resetFailed && (respValid || !reqReady)) begin
        $display("after reset reqReady was %0b and respValid was %0b before any request",
                 reqReady, respValid);
        resetFailed = 1'b1;
        errorCount++;
      end
      if (respValid && !respWasValid) riseCycle = cycle;
      if (respValid && respReady) begin
        responseCount++;
        if (pending.size() == 0) begin
          $display("response %0d arrived with no request outstanding", responseCount);
          errorCount++;
        end else begin
          head = pending.pop_front();
          checkResponse(head, response.result, riseCycle - int'(head.acceptCycle) - 1);
        end
      end
      if (reqValid && reqReady) begin
        // an earlier request without its response counts as pending too.
        if (respValid || (pending.size() != 0)) begin
          $display("a request was accepted while a response was pending");
          errorCount++;
        end
        if ((acceptCount == 0) && !resetFailed) begin
          $display("reset state: reqReady high and respValid low before the first request ok");
        end
        entry.ciN         = request.ciN;
        entry.usCount     = request.dataA[15:0];
        entry.expected    = expected;
        entry.acceptCycle = cycle;
        pending.push_back(entry);
        acceptCount++;
      end
      respWasValid = respValid;
      cycle++;
    end
  end

endmodule

/* tests/ciUnit_chk.sv */
`timescale 1ns/100ps

module ciUnitChk (
  input logic               s_systemClock,
  input logic               s_pllLocked,
  input logic               reqValid,
  input logic               reqReady,
  input logic               respValid,
  input logic               respReady,
  input ciPkg::ciResponse_t response
);

  int   assertFailures = 0;
  logic inFlight;

  // set on acceptance, cleared when the response transfers.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      inFlight <= 1'b0;
    end else if (reqValid && reqReady) begin
      inFlight <= 1'b1;
    end else if (respValid && respReady) begin
      inFlight <= 1'b0;
    end
  end

  // nothing may be pending when reset lets go.
  respLowAfterReset: assert property (@(posedge s_systemClock)
      $rose(s_pllLocked) |-> !respValid)
    else begin
      $error("respValid high right after reset");
      assertFailures++;
    end

  respHeld: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
      respValid && !respReady |=> respValid && $stable(response))
    else begin
      $error("pending response dropped or changed");
      assertFailures++;
    end

  noAcceptWhilePending: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
      inFlight |-> !reqReady)
    else begin
      $error("reqReady high with a response pending");
      assertFailures++;
    end

endmodule

bind ciSequencer ciUnitChk u_ciUnitChk (.*);

/* verilog/ciUnit.sv */
`timescale 1ns/100ps

module ciUnit (
  input  logic               s_systemClock,
  input  logic               s_pllLocked,
  input  logic               reqValid,
  output logic               reqReady,
  input  ciPkg::ciRequest_t  request,
  output logic               respValid,
  input  logic               respReady,
  output ciPkg::ciResponse_t response
);

  ciPkg::ciEngine_t                  engine;
  logic                              launch;
  logic [ciPkg::delayCountWidth-1:0] delayCount;
  operandPkg::ciOperand_t            operandA;
  logic [31:0]                       operandB;
  logic                              expired;
  logic                              resultReady;
  logic [31:0]                       result;
  wire                               launchDelay = launch && (engine == ciPkg::engineDelay);

  ciSequencer u_ciSequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .reqValid     (reqValid),
    .reqReady     (reqReady),
    .request      (request),
    .respValid    (respValid),
    .respReady    (respReady),
    .response     (response),
    .engine       (engine),
    .launch       (launch),
    .delayCount   (delayCount),
    .operandA     (operandA),
    .operandB     (operandB),
    .expired      (expired),
    .resultReady  (resultReady),
    .result       (result)
  );

  microDelayTimer u_microDelayTimer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .launchDelay  (launchDelay),
    .delayCount   (delayCount),
    .expired      (expired)
  );

  ciDatapath u_ciDatapath (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .launch       (launch),
    .engine       (engine),
    .operandA     (operandA),
    .operandB     (operandB),
    .resultReady  (resultReady),
    .result       (result)
  );

endmodule

/* verilog/ciDatapath.sv */
`timescale 1ns/100ps

module ciDatapath (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  logic                   launch,
  input  ciPkg::ciEngine_t       engine,
  input  operandPkg::ciOperand_t operandA,
  input  logic [31:0]            operandB,
  output logic                   resultReady,
  output logic [31:0]            result
);

  logic [31:0] swapResult;
  logic        singleCycle;
  logic        grayValid;
  logic [7:0]  gray;

  // mode 1 swaps inside each half, mode 0 reverses the whole word.
  assign swapResult = operandB[0]
      ? {operandA.bytes[2], operandA.bytes[3], operandA.bytes[0], operandA.bytes[1]}
      : {operandA.bytes[0], operandA.bytes[1], operandA.bytes[2], operandA.bytes[3]};

  assign singleCycle = launch &&
      ((engine == ciPkg::engineSwap) || (engine == ciPkg::engineNone));

  grayscaleConverter u_grayscaleConverter (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .pixelValid   (launch && (engine == ciPkg::engineGray)),
    .pixel        (operandA.pixel.rgb),
    .grayValid    (grayValid),
    .gray         (gray)
  );

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) resultReady <= 1'b0;
    else resultReady <= singleCycle || grayValid;  // one-cycle pulse.
  end

  always_ff @(posedge s_systemClock) begin
    if (singleCycle) begin
      result <= (engine == ciPkg::engineSwap) ? swapResult : 32'd0;
    end else if (grayValid) begin
      result <= {24'd0, gray};
    end
  end

endmodule

/* verilog/ciSequencer.sv */
`timescale 1ns/100ps

module ciSequencer (
  input  logic                                s_systemClock,
  input  logic                                s_pllLocked,
  input  logic                                reqValid,
  output logic                                reqReady,
  input  ciPkg::ciRequest_t                   request,
  output logic                                respValid,
  input  logic                                respReady,
  output ciPkg::ciResponse_t                  response,
  output ciPkg::ciEngine_t                    engine,
  output logic                                launch,
  output logic [ciPkg::delayCountWidth-1:0]   delayCount,
  output operandPkg::ciOperand_t              operandA,
  output logic [31:0]                         operandB,
  input  logic                                expired,
  input  logic                                resultReady,
  input  logic [31:0]                         result
);

  typedef enum logic [1:0] {
    idle,
    launching,
    waiting,
    responding
  } seqState_t;

  seqState_t state;
  logic      engineDone;

  // the delay engine reports through the timer, all others through the datapath.
  assign engineDone = (engine == ciPkg::engineDelay) ? expired : resultReady;

  assign reqReady  = (state == idle);
  assign respValid = (state == responding);
  assign launch    = (state == launching);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state  <= idle;
      engine <= ciPkg::engineNone;
    end else begin
      case (state)
        idle: begin
          if (reqValid) begin
            state <= launching;
            case (request.ciN)
              ciPkg::ciSwapByte: engine <= ciPkg::engineSwap;
              ciPkg::ciDelay:    engine <= ciPkg::engineDelay;
              ciPkg::ciGray:     engine <= ciPkg::engineGray;
              default:           engine <= ciPkg::engineNone;  // answered with zero.
            endcase
          end
        end
        launching: state <= waiting;
        waiting: begin
          if (engineDone) state <= responding;
        end
        responding: begin
          if (respReady) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // request payload, captured on the accepting edge.
  always_ff @(posedge s_systemClock) begin
    if (reqReady && reqValid) begin
      operandA   <= request.dataA;
      operandB   <= request.dataB;
      delayCount <= request.dataA[ciPkg::delayCountWidth-1:0];
    end
  end

  // response stays put while it waits for respReady.
  always_ff @(posedge s_systemClock) begin
    if ((state == waiting) && engineDone) begin
      if (engine == ciPkg::engineDelay) response.result <= 32'd0;
      else response.result <= result;
    end
  end

endmodule

/* verilog/microDelayTimer.sv */
`timescale 1ns/100ps

module microDelayTimer (
  input  logic                              s_systemClock,
  input  logic                              s_pllLocked,
  input  logic                              launchDelay,
  input  logic [ciPkg::delayCountWidth-1:0] delayCount,
  output logic                              expired
);

  logic [$clog2(ciPkg::ticksPerMicrosecond)-1:0] prescale;
  logic [ciPkg::delayCountWidth-1:0]             usCount;
  logic                                          lastTick;

  assign lastTick = (prescale == $bits(prescale)'(ciPkg::ticksPerMicrosecond - 1));

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      prescale <= '0;
      usCount  <= '0;
      expired  <= 1'b0;
    end else begin
      expired <= 1'b0;
      if (launchDelay) begin
        usCount  <= delayCount;
        prescale <= $bits(prescale)'(1);  // the launch cycle is the first tick.
        expired  <= (delayCount == '0);
      end else if (usCount != '0) begin
        if (lastTick) begin
          prescale <= '0;
          usCount  <= usCount - 1'b1;
          // last microsecond done.
          expired  <= (usCount == ciPkg::delayCountWidth'(1));
        end else begin
          prescale <= prescale + 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/grayscaleConverter.sv */
`timescale 1ns/100ps

module grayscaleConverter (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  input  logic                pixelValid,
  input  operandPkg::rgb565_t pixel,
  output logic                grayValid,
  output logic [7:0]          gray
);

  logic [7:0]  red8;
  logic [7:0]  green8;
  logic [7:0]  blue8;
  logic        stageOneValid;
  logic [15:0] redProduct;
  logic [15:0] greenProduct;
  logic [15:0] blueProduct;
  logic [17:0] productSum;

  // widen each field by repeating its top bits.
  assign red8   = {pixel.red, pixel.red[4:2]};
  assign green8 = {pixel.green, pixel.green[5:4]};
  assign blue8  = {pixel.blue, pixel.blue[4:2]};

  assign productSum = 18'(redProduct) + 18'(greenProduct) + 18'(blueProduct);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stageOneValid <= 1'b0;
      grayValid     <= 1'b0;
    end else begin
      stageOneValid <= pixelValid;
      grayValid     <= stageOneValid;
    end
  end

  // stage one, weighted channels.
  always_ff @(posedge s_systemClock) begin
    redProduct   <= red8 * operandPkg::grayWeightRed;
    greenProduct <= green8 * operandPkg::grayWeightGreen;
    blueProduct  <= blue8 * operandPkg::grayWeightBlue;
  end

  // stage two. weights sum to 256 so the shifted sum fits in a byte.
  always_ff @(posedge s_systemClock) begin
    gray <= 8'(productSum >> operandPkg::grayShift);
  end

endmodule

/* verilog/ciPkg.sv */
package ciPkg;

  // custom instruction numbers as seen on ciN.
  localparam logic [7:0] ciSwapByte = 8'd1;
  localparam logic [7:0] ciDelay    = 8'd6;
  localparam logic [7:0] ciGray     = 8'd9;

  // system clock runs at 25 MHz.
  localparam int unsigned ticksPerMicrosecond = 25;
  localparam int unsigned delayCountWidth     = 16;

  // engine picked once per request by the sequencer.
  typedef enum logic [1:0] {
    engineSwap,
    engineDelay,
    engineGray,
    engineNone
  } ciEngine_t;

  typedef struct packed {
    logic [7:0]             ciN;
    operandPkg::ciOperand_t dataA;
    logic [31:0]            dataB;
  } ciRequest_t;

  typedef struct packed {
    logic [31:0] result;
  } ciResponse_t;

endpackage

/* verilog/operandPkg.sv */
package operandPkg;

  // one RGB565 pixel, red in the top bits.
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // pixel placement inside a 32-bit operand.
  typedef struct packed {
    logic [15:0] spare;  // ignored by the converter.
    rgb565_t     rgb;
  } pixelWord_t;

  // operand A read as four bytes by the swap and as a pixel by the converter.
  typedef union packed {
    logic [3:0][7:0] bytes;
    pixelWord_t      pixel;
  } ciOperand_t;

  // luma weights scaled by 256, they sum to 256.
  localparam logic [7:0] grayWeightRed   = 8'd54;
  localparam logic [7:0] grayWeightGreen = 8'd183;
  localparam logic [7:0] grayWeightBlue  = 8'd19;

  localparam int unsigned grayShift = 8;

endpackage
